//--- Makefile
# Verilator build and run for the spi slave testbench

VERILATOR  ?= verilator
TOP        ?= spi_slave_tb
FILELIST   ?= spi_slave.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a stopped run has no pass line and counts as failed
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/spi_slave_pkg.sv
/* spi slave shared definitions
   map layout, core packet format, config and command bytes */
package spi_slave_pkg;

   //##################################################
   // sizes
   //##################################################
   localparam int unsigned AW = 32;            // core address width
   localparam int unsigned PW = 2 * AW + 40;   // emesh packet width, 104
   localparam int unsigned NREGS = 64;         // full spi map

   //##################################################
   // register map
   //##################################################
   localparam int unsigned ADDR_CONFIG = 0;    // mode and enables
   localparam int unsigned ADDR_STATUS = 1;    // bit 0 = core data ready
   // 2 to 7 reserved, read as zero
   localparam int unsigned CORE_BASE = 8;      // 8 capture bytes, read only
   localparam int unsigned USER_BASE = 16;     // 48 user bytes up to 63

   //##################################################
   // core write-back packet
   //##################################################
   // msb first, same order as on the emesh side
   typedef struct packed
   {
      logic          write;      // write transaction
      logic [1:0]    datamode;   // access size
      logic [4:0]    ctrlmode;   // routing and control hints
      logic [AW-1:0] dstaddr;    // destination address
      logic [AW-1:0] srcaddr;    // source or upper data word
      logic [AW-1:0] data;       // lower data word
   } emesh_packet_t;

   // config byte, bit 0 is spi_en
   typedef struct packed
   {
      logic spare;      // bit 7, unused
      logic emode;      // epiphany auto mode, only passed out
      logic user_en;    // user space writable
      logic lsbfirst;   // bit order on the wire
      logic cpha;       // clock phase
      logic cpol;       // idle level of sclk
      logic irq_en;     // interrupt enable
      logic spi_en;     // status and user writes allowed
   } spi_cfg_t;

   // first byte of every transaction
   typedef struct packed
   {
      logic       read;    // 1 = read burst, 0 = write burst
      logic       spare;   // ignored
      logic [5:0] addr;    // start address
   } spi_cmd_t;

   // write request from the io block
   typedef struct packed
   {
      logic       wr_en;   // one cycle strobe
      logic [5:0] addr;    // target byte
      logic [7:0] data;    // value to write
   } reg_wr_t;

endpackage

//--- hw/spi_slave.sv
`timescale 1ns/1ps
/* spi slave configuration port
   pin side io block plus 64 byte register map, single clock */
module spi_slave
(
   input  logic                          clk,
   input  logic                          nreset,
   // spi pins
   input  logic                          sclk,
   input  logic                          ss_n,
   input  logic                          mosi,
   output logic                          miso,
   output logic                          miso_oe,    // drive miso only when selected
   // core side
   input  logic                          access_in,
   input  spi_slave_pkg::emesh_packet_t  packet_in,
   output logic                          irq,
   output spi_slave_pkg::spi_cfg_t       cfg
);

   spi_slave_pkg::reg_wr_t reg_wr;   // io to map write
   logic [5:0] rd_addr;
   logic [7:0] rd_data;

   //##################################################
   // pin side
   //##################################################
   spi_slave_io u_io
   (
      .clk     (clk),
      .nreset  (nreset),
      .sclk    (sclk),
      .ss_n    (ss_n),
      .mosi    (mosi),
      .cfg     (cfg),
      .rd_data (rd_data),
      .miso    (miso),
      .miso_oe (miso_oe),
      .reg_wr  (reg_wr),
      .rd_addr (rd_addr)
   );

   //##################################################
   // register map
   //##################################################
   spi_slave_regs u_regs
   (
      .clk       (clk),
      .nreset    (nreset),
      .reg_wr    (reg_wr),
      .rd_addr   (rd_addr),
      .access_in (access_in),
      .packet_in (packet_in),
      .rd_data   (rd_data),
      .cfg       (cfg),
      .irq       (irq)
   );

endmodule

//--- spi/spi_slave_io.sv
`timescale 1ns/1ps
/* spi slave pin side, oversampled in the core clock
   shifts command and data bytes, drives writes, reads and miso */
module spi_slave_io
(
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     sclk,      // spi clock pin
   input  logic                     ss_n,      // slave select, low active
   input  logic                     mosi,
   input  spi_slave_pkg::spi_cfg_t  cfg,       // live config level
   input  logic [7:0]               rd_data,   // map byte at rd_addr
   output logic                     miso,
   output logic                     miso_oe,
   output spi_slave_pkg::reg_wr_t   reg_wr,
   output logic [5:0]               rd_addr
);

   logic [1:0] sclk_sync;        // two flop synchronizers
   logic [1:0] ss_sync;
   logic [1:0] mosi_sync;
   logic       sclk_q;           // delayed copies for edge detect
   logic       ss_q;
   logic       active;
   logic       ss_fall;
   logic       sclk_rise;
   logic       sclk_fall;
   logic       lead_edge;
   logic       trail_edge;
   logic       sample_edge;
   logic       shift_edge;
   logic       byte_done;
   logic       cpol_q;           // mode held for one transaction
   logic       cpha_q;
   logic       lsb_q;
   logic [2:0] bit_cnt;
   logic       data_phase;       // command byte already taken
   logic       read_q;
   logic [5:0] addr_q;
   logic [7:0] rx_shift;
   logic [7:0] rx_byte;
   logic [7:0] tx_shift;
   logic       wr_en_q;
   logic [5:0] wr_addr_q;
   logic [7:0] wr_data_q;
   spi_slave_pkg::spi_cmd_t cmd;

   //##################################################
   // pin sync and edge detect
   //##################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         sclk_sync <= 2'b00;
         ss_sync   <= 2'b11;   // deselected
         mosi_sync <= 2'b00;
         sclk_q    <= 1'b0;
         ss_q      <= 1'b1;
      end
      else
      begin
         sclk_sync <= {sclk_sync[0], sclk};
         ss_sync   <= {ss_sync[0], ss_n};
         mosi_sync <= {mosi_sync[0], mosi};
         sclk_q    <= sclk_sync[1];
         ss_q      <= ss_sync[1];
      end

   assign active    = ~ss_sync[1];
   assign ss_fall   = ss_q & ~ss_sync[1];   // start of transaction
   assign sclk_rise = sclk_sync[1] & ~sclk_q;
   assign sclk_fall = ~sclk_sync[1] & sclk_q;

   // leading edge leaves the cpol idle level
   assign lead_edge   = cpol_q ? sclk_fall : sclk_rise;
   assign trail_edge  = cpol_q ? sclk_rise : sclk_fall;
   assign sample_edge = active & (cpha_q ? trail_edge : lead_edge);
   assign shift_edge  = active & (cpha_q ? lead_edge : trail_edge);

   // mode taken at ss_n fall, so config writes apply next transaction
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         cpol_q <= 1'b0;
         cpha_q <= 1'b0;
         lsb_q  <= 1'b0;
      end
      else if (ss_fall)
      begin
         cpol_q <= cfg.cpol;
         cpha_q <= cfg.cpha;
         lsb_q  <= cfg.lsbfirst;
      end

   //##################################################
   // receive side
   //##################################################
   // byte including the bit sampled this cycle
   assign rx_byte = lsb_q ? {mosi_sync[1], rx_shift[7:1]} : {rx_shift[6:0], mosi_sync[1]};
   assign cmd       = rx_byte;
   assign byte_done = sample_edge & (bit_cnt == 3'd7);

   always_ff @(posedge clk)
      if (sample_edge)
         rx_shift <= rx_byte;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         bit_cnt    <= 3'd0;
         data_phase <= 1'b0;
         read_q     <= 1'b0;
         addr_q     <= 6'd0;
      end
      else if (!active)
      begin
         bit_cnt    <= 3'd0;   // ss_n high ends the burst
         data_phase <= 1'b0;
      end
      else if (sample_edge)
      begin
         bit_cnt <= bit_cnt + 3'd1;   // wraps per byte
         if (byte_done && !data_phase)
         begin
            data_phase <= 1'b1;
            read_q     <= cmd.read;
            addr_q     <= cmd.addr;
         end
         else if (byte_done && !read_q)
            addr_q <= addr_q + 6'd1;  // next write byte, wraps at 63
      end
      else if (shift_edge && bit_cnt == 3'd0 && data_phase && read_q)
         addr_q <= addr_q + 6'd1;     // byte just loaded for miso

   //##################################################
   // write strobe
   //##################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         wr_en_q <= 1'b0;
      else
         wr_en_q <= byte_done & data_phase & ~read_q;

   always_ff @(posedge clk)
      if (byte_done)
      begin
         wr_addr_q <= addr_q;
         wr_data_q <= rx_byte;
      end

   assign reg_wr = '{wr_en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

   //##################################################
   // miso serializer
   //##################################################
   // bit_cnt of zero on a shift edge marks the byte boundary
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         tx_shift <= 8'h00;
      else if (ss_fall)
         tx_shift <= 8'h00;           // zeros during command byte
      else if (shift_edge)
      begin
         if (bit_cnt == 3'd0)
            tx_shift <= (data_phase && read_q) ? rd_data : 8'h00;
         else if (lsb_q)
            tx_shift <= {1'b0, tx_shift[7:1]};
         else
            tx_shift <= {tx_shift[6:0], 1'b0};
      end

   assign miso    = lsb_q ? tx_shift[0] : tx_shift[7];
   assign miso_oe = active;
   assign rd_addr = addr_q;

endmodule

//--- spi/spi_slave_regs.sv
`timescale 1ns/1ps
/* spi slave register map
   config, status, core write-back capture and user bytes with read mux */
module spi_slave_regs
(
   input  logic                          clk,
   input  logic                          nreset,
   input  spi_slave_pkg::reg_wr_t        reg_wr,      // write from io block
   input  logic [5:0]                    rd_addr,
   input  logic                          access_in,   // core write-back strobe
   input  spi_slave_pkg::emesh_packet_t  packet_in,
   output logic [7:0]                    rd_data,
   output spi_slave_pkg::spi_cfg_t       cfg,
   output logic                          irq
);

   localparam int unsigned NUSER = spi_slave_pkg::NREGS - spi_slave_pkg::USER_BASE;

   spi_slave_pkg::spi_cfg_t cfg_q;
   logic [7:0]  status_q;
   logic [63:0] core_q;                  // {srcaddr, data}
   logic [7:0]  user_q [NUSER];
   logic        cfg_wr;
   logic        status_wr;
   logic        user_wr;
   logic        is_user_wr;
   logic        is_user_rd;
   logic        is_core_rd;
   logic [5:0]  wr_user_idx;
   logic [5:0]  rd_user_idx;

   //##################################################
   // write decode and gating
   //##################################################
   assign cfg_wr    = reg_wr.wr_en &
                      (reg_wr.addr == 6'(spi_slave_pkg::ADDR_CONFIG));  // always open
   assign status_wr = reg_wr.wr_en & cfg_q.spi_en &
                      (reg_wr.addr == 6'(spi_slave_pkg::ADDR_STATUS));
   assign is_user_wr = reg_wr.addr >= 6'(spi_slave_pkg::USER_BASE);
   assign user_wr   = reg_wr.wr_en & is_user_wr & cfg_q.spi_en & cfg_q.user_en;
   // 2 to 15 fall through, nothing written there

   assign wr_user_idx = reg_wr.addr - 6'(spi_slave_pkg::USER_BASE);
   assign rd_user_idx = rd_addr - 6'(spi_slave_pkg::USER_BASE);

   //##################################################
   // config
   //##################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         cfg_q <= '0;
      else if (cfg_wr)
         cfg_q <= reg_wr.data;

   assign cfg = cfg_q;

   //##################################################
   // status
   //##################################################
   // bit 0 sticks until an spi write replaces it
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         status_q <= 8'h00;
      else if (status_wr)
         status_q <= reg_wr.data | {7'd0, access_in};  // new packet wins a tie
      else if (access_in)
         status_q[0] <= 1'b1;                          // data ready

   assign irq = cfg_q.irq_en & status_q[0];

   //##################################################
   // core capture and user space
   //##################################################
   always_ff @(posedge clk)
      if (access_in)
         core_q <= {packet_in.srcaddr, packet_in.data};   // later packets overwrite

   always_ff @(posedge clk)
      if (user_wr)
         user_q[wr_user_idx] <= reg_wr.data;

   //##################################################
   // read mux
   //##################################################
   assign is_user_rd = rd_addr >= 6'(spi_slave_pkg::USER_BASE);
   assign is_core_rd = ~is_user_rd & (rd_addr >= 6'(spi_slave_pkg::CORE_BASE));

   always_comb
   begin
      rd_data = 8'h00;                  // reserved 2 to 7
      if (is_user_rd)
         rd_data = user_q[rd_user_idx];
      else if (is_core_rd)
         rd_data = core_q[{rd_addr[2:0], 3'b000} +: 8];   // byte 8 = data[7:0]
      else if (rd_addr == 6'(spi_slave_pkg::ADDR_CONFIG))
         rd_data = cfg_q;
      else if (rd_addr == 6'(spi_slave_pkg::ADDR_STATUS))
         rd_data = status_q;
   end

endmodule

//--- spi_slave.f
common/spi_slave_pkg.sv
spi/spi_slave_io.sv
spi/spi_slave_regs.sv
hw/spi_slave.sv
verification/spi_slave_assertions.sv
verification/spi_slave_tb.sv

//--- verification/spi_slave_assertions.sv
`timescale 1ns/1ps
/* spi slave bus and interrupt checks
   bound into the top level */
module spi_slave_assertions
(
   input logic                     clk,
   input logic                     nreset,
   input logic                     ss_n,
   input logic                     miso_oe,
   input logic                     irq,
   input logic                     access_in,
   input spi_slave_pkg::spi_cfg_t  cfg,
   input spi_slave_pkg::reg_wr_t   reg_wr
);

   //##################################################
   // interrupt
   //##################################################
   // rises only with irq_en, after a map write or a core packet
   irq_needs_enable : assert property (@(posedge clk) disable iff (!nreset)
      $rose(irq) |-> cfg.irq_en && ($past(access_in) || $past(reg_wr.wr_en)))
      else $error("irq rose without irq_en, a register write or a core packet");

   //##################################################
   // pin side
   //##################################################
   // two sync flops, three samples of ss_n high are enough
   oe_drops : assert property (@(posedge clk) disable iff (!nreset)
      (ss_n && $past(ss_n) && $past(ss_n, 2)) |-> !miso_oe)
      else $error("miso_oe still high after ss_n went high");

   strobe_one_cycle : assert property (@(posedge clk) disable iff (!nreset)
      reg_wr.wr_en |=> !reg_wr.wr_en)
      else $error("write strobe longer than one cycle");

   no_strobe_idle : assert property (@(posedge clk) disable iff (!nreset)
      reg_wr.wr_en |-> !ss_n)
      else $error("write strobe while ss_n is high");

endmodule

bind spi_slave spi_slave_assertions u_spi_slave_assertions
(
   .clk       (clk),
   .nreset    (nreset),
   .ss_n      (ss_n),
   .miso_oe   (miso_oe),
   .irq       (irq),
   .access_in (access_in),
   .cfg       (cfg),
   .reg_wr    (reg_wr)
);

//--- verification/spi_slave_tb.sv
`timescale 1ns/1ps
/* spi slave testbench
   spi master model, register map model and directed tests */
module spi_slave_tb;

   typedef logic [7:0] byte_q_t [$];

   localparam int HALF_SCLK  = 4;                     // clk cycles per sclk half period
   localparam int XFER_BYTES = 900;                   // bytes on the bus over all tests
   localparam int MAX_CYCLES = XFER_BYTES * 80 + 2000;

   logic clk;
   logic nreset;
   logic sclk;
   logic ss_n;
   logic mosi;
   logic miso;
   logic miso_oe;
   logic access_in;
   logic irq;
   spi_slave_pkg::emesh_packet_t packet_in;
   spi_slave_pkg::spi_cfg_t      cfg;
   logic       cpol;              // bus mode as the master sees it
   logic       cpha;
   logic       lsbfirst;
   logic [7:0] map_model [64];    // expected register map
   int errors;
   int checks;
   int cycles = 0;

   spi_slave u_spi_slave
   (
      .clk       (clk),
      .nreset    (nreset),
      .sclk      (sclk),
      .ss_n      (ss_n),
      .mosi      (mosi),
      .miso      (miso),
      .miso_oe   (miso_oe),
      .access_in (access_in),
      .packet_in (packet_in),
      .irq       (irq),
      .cfg       (cfg)
   );

   always #2 clk = ~clk;   // 4 ns period

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, tests did not finish", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   //##################################################
   // helpers
   //##################################################
   task automatic wait_clks(input int n);
      repeat (n) @(posedge clk);
   endtask

   // half sclk period, miso taken at the last falling clk edge
   task automatic wait_half_sample(output logic bit_in);
      repeat (HALF_SCLK - 1) @(posedge clk);
      @(negedge clk);
      bit_in = miso;
      @(posedge clk);
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("Mismatch at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
      end
   endtask

   // write gating as the map should apply it
   function automatic void model_write(input logic [5:0] addr, input logic [7:0] data);
      spi_slave_pkg::spi_cfg_t c;
      c = map_model[0];
      if (addr == 6'(spi_slave_pkg::ADDR_CONFIG))
         map_model[addr] = data;                       // always open
      else if (addr == 6'(spi_slave_pkg::ADDR_STATUS) && c.spi_en)
         map_model[addr] = data;
      else if (addr >= 6'(spi_slave_pkg::USER_BASE) && c.spi_en && c.user_en)
         map_model[addr] = data;
   endfunction

   //##################################################
   // spi master
   //##################################################
   // command byte first, rx holds the data bytes only
   task automatic spi_xfer(input logic [7:0] cmd, input byte_q_t tx_bytes,
                           output byte_q_t rx_bytes);
      byte_q_t    frame;
      logic [7:0] in_byte;
      logic       bit_in;
      int         idx;
      frame = tx_bytes;
      frame.push_front(cmd);
      rx_bytes = {};
      @(posedge clk);
      sclk <= cpol;                 // new idle level while still deselected
      wait_clks(HALF_SCLK);
      ss_n <= 1'b0;
      foreach (frame[n])
      begin
         for (int b = 0; b < 8; b++)
         begin
            idx = lsbfirst ? b : 7 - b;
            if (!cpha)
            begin
               mosi <= frame[n][idx];       // set up before leading edge
               wait_half_sample(bit_in);
               sclk <= ~cpol;               // leading, slave samples
               wait_clks(HALF_SCLK);
               sclk <= cpol;
            end
            else
            begin
               wait_clks(HALF_SCLK);
               sclk <= ~cpol;               // leading, slave shifts
               mosi <= frame[n][idx];
               wait_half_sample(bit_in);
               sclk <= cpol;                // trailing, slave samples
            end
            in_byte[idx] = bit_in;
         end
         if (n > 0)
            rx_bytes.push_back(in_byte);
      end
      @(negedge clk);
      check_byte({7'd0, miso_oe}, 8'h01, "miso_oe while selected");
      wait_clks(2 * HALF_SCLK);             // last strobe lands first
      ss_n <= 1'b1;
      wait_clks(2 * HALF_SCLK);
      @(negedge clk);
      check_byte({7'd0, miso_oe}, 8'h00, "miso_oe after deselect");
   endtask

   task automatic write_burst(input logic [5:0] addr, input byte_q_t data);
      byte_q_t rx;
      spi_xfer({2'b00, addr}, data, rx);
      foreach (data[i])
         model_write(6'(addr + i), data[i]);    // address wraps at 63
   endtask

   task automatic write_byte(input logic [5:0] addr, input logic [7:0] value);
      byte_q_t one;
      one.push_back(value);
      write_burst(addr, one);
   endtask

   task automatic read_expect(input logic [5:0] addr, input int n);
      byte_q_t    tx;
      byte_q_t    rx;
      logic [5:0] a;
      repeat (n) tx.push_back(8'h00);
      spi_xfer({2'b10, addr}, tx, rx);
      foreach (rx[i])
      begin
         a = 6'(addr + i);
         check_byte(rx[i], map_model[a], $sformatf("map byte %0d", a));
      end
   endtask

   // mode bits apply from the next transaction on
   task automatic set_config(input logic [7:0] value);
      spi_slave_pkg::spi_cfg_t c;
      c = value;
      write_byte(6'(spi_slave_pkg::ADDR_CONFIG), value);
      cpol     = c.cpol;
      cpha     = c.cpha;
      lsbfirst = c.lsbfirst;
      check_byte(cfg, map_model[0], "cfg port");
   endtask

   task automatic check_irq(input logic exp);
      @(negedge clk);
      check_byte({7'd0, irq}, {7'd0, exp}, "irq");
   endtask

   task automatic send_packet();
      spi_slave_pkg::emesh_packet_t pkt;
      logic [63:0] cap;
      pkt = {8'($urandom), 32'($urandom), 32'($urandom), 32'($urandom)};
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(posedge clk);
      access_in <= 1'b0;
      cap = {pkt.srcaddr, pkt.data};            // data[7:0] lands at byte 8
      for (int k = 0; k < 8; k++)
         map_model[6'(spi_slave_pkg::CORE_BASE + k)] = cap[8*k +: 8];
      map_model[1][0] = 1'b1;                   // data ready
      wait_clks(2);
   endtask

   // random bytes, config and status slots keep their model value
   task automatic user_burst(input int start, input int len);
      byte_q_t    data;
      logic [5:0] a;
      for (int i = 0; i < len; i++)
      begin
         a = 6'(start + i);
         data.push_back(a < 6'd2 ? map_model[a] : 8'($urandom));
      end
      write_burst(6'(start), data);
      read_expect(6'(start), len);
   endtask

   //##################################################
   // tests
   //##################################################
   task automatic reset_state();
      @(negedge clk);
      check_byte({7'd0, irq}, 8'h00, "irq after reset");
      check_byte({7'd0, miso_oe}, 8'h00, "miso_oe after reset");
      read_expect(6'd0, 2);
   endtask

   task automatic write_gating();
      byte_q_t fill;
      byte_q_t junk;
      for (int a = 16; a < 64; a++)
         fill.push_back(8'(a * 7 + 3));    // known user contents
      repeat (20) junk.push_back(8'($urandom));
      set_config(8'h21);                   // spi_en, user_en
      write_burst(6'd16, fill);
      read_expect(6'd16, 48);
      set_config(8'h40);                   // spi_en clear, emode only
      write_burst(6'd1, junk);             // status, reserved, user 16..20
      read_expect(6'd0, 2);
      read_expect(6'd16, 8);
      set_config(8'h01);                   // user space still locked
      write_burst(6'd40, junk);
      read_expect(6'd40, 20);
      write_byte(6'd1, 8'h80);
      read_expect(6'd0, 2);
      write_byte(6'd1, 8'h00);
   endtask

   task automatic mode_sweep();
      int start;
      for (int m = 0; m < 8; m++)
      begin
         set_config(8'h21 | 8'(m << 2));   // cpol, cpha, lsbfirst from m
         start = 16 + int'($urandom_range(47));
         user_burst(start, start > 56 ? 72 - start : int'($urandom_range(16, 4)));
         start = 56 + int'($urandom_range(7));
         user_burst(start, 72 - start);    // wraps through config and status
      end
      set_config(8'h21);
   endtask

   task automatic core_capture_irq();
      send_packet();
      read_expect(6'd8, 8);
      read_expect(6'd1, 1);
      check_irq(1'b0);                     // irq_en still clear
      set_config(8'h23);
      check_irq(1'b1);
      write_byte(6'd1, 8'h00);
      check_irq(1'b0);
      send_packet();                       // overwrites capture
      check_irq(1'b1);
      read_expect(6'd8, 8);
      write_byte(6'd1, 8'h00);
      set_config(8'h21);
   endtask

   task automatic read_only_bytes();
      byte_q_t junk;
      repeat (14) junk.push_back(8'($urandom));
      write_burst(6'd2, junk);
      read_expect(6'd0, 16);
   endtask

   initial
   begin
      void'($urandom(73));
      clk       = 1'b0;
      nreset    = 1'b0;
      sclk      = 1'b0;
      ss_n      = 1'b1;
      mosi      = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      cpol      = 1'b0;
      cpha      = 1'b0;
      lsbfirst  = 1'b0;
      errors    = 0;
      checks    = 0;
      foreach (map_model[a])
         map_model[a] = 8'h00;
      repeat (2) @(posedge clk);
      nreset <= 1'b1;
      wait_clks(2);
      reset_state();
      write_gating();
      mode_sweep();
      core_capture_irq();
      read_only_bytes();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
